//--- list.f
source/cpu_pkg.sv
source/alu.sv
source/regfile.sv
source/program_counter.sv
source/word_ram.sv
source/control_decoder.sv
source/cpu_top.sv
sim/cpu_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
SIM_FLAGS = --binary -j 0
TOP       = cpu_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# a failing check ends in $fatal, so the binary exits non-zero
sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/cpu_tb.sv
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

	localparam int max_prog_len = 96; // longest program in words, with the tail
	localparam int num_runs     = 6;  // programs run over the whole testbench
	localparam int wd_cycles    = 200 * max_prog_len * num_runs + 4000;
	localparam logic [mem_aw-1:0] slot_base = 8'hf0; // one halt slot per run

	logic              clk;
	logic              reset;
	logic              run;
	logic              halted;
	logic              host_we;
	logic [mem_aw-1:0] host_addr;
	logic [data_w-1:0] host_wdata;
	logic [data_w-1:0] host_rdata;

	instr_t prog[$];    // program being built
	int     seed = 17121;
	int     runs;       // programs finished, picks the halt slot

	cpu_top uut (
		.clk        (clk),
		.reset      (reset),
		.run        (run),
		.halted     (halted),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// whole run bounded by program lengths
	initial begin
		#(wd_cycles * 10);
		abort_run("watchdog expired before all tests finished");
	end

	task automatic abort_run(string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_word(string what, logic [data_w-1:0] got, logic [data_w-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
	endtask

	// flags a compare of a with b should leave
	function automatic flags_t cmp_flags(logic [data_w-1:0] a, logic [data_w-1:0] b);
		flags_t f;
		f   = '0;
		f.z = (a == b);
		f.n = ($signed(a) < $signed(b));
		f.l = (a < b);
		return f;
	endfunction

	// bit set where the marker add ran, i.e. branch not taken
	function automatic logic [data_w-1:0] skip_mask(flags_t f);
		logic [5:0] taken;
		taken[0] = f.z;          // eq
		taken[1] = !f.z;         // ne
		taken[2] = !f.n && !f.z; // gt
		taken[3] = f.n || f.z;   // le
		taken[4] = !f.l && !f.z; // hi
		taken[5] = f.l || f.z;   // ls
		return {10'b0, ~taken};
	endfunction

	task automatic check_flags_word(string what, flags_t f, logic [data_w-1:0] got);
		logic [data_w-1:0] exp;
		exp = skip_mask(f);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t: %s markers %h expected %h (z%b n%b l%b)",
				$time, what, got, exp, f.z, f.n, f.l));
	endtask

	// encoders, one per instruction form
	function automatic instr_t enc_rr(op_t op, int rd, int rs);
		instr_t w;
		w.op    = op;
		w.rdest = 4'(rd);
		w.imm8  = {4'h0, 4'(rs)}; // rsrc in the low nibble
		return w;
	endfunction

	function automatic instr_t enc_ri(op_t op, int rd, int imm);
		instr_t w;
		w.op    = op;
		w.rdest = 4'(rd);
		w.imm8  = 8'(imm);
		return w;
	endfunction

	function automatic instr_t enc_br(cond_t c, int disp);
		instr_t w;
		w.op    = op_bcond;
		w.rdest = c;
		w.imm8  = 8'(disp); // relative to the next word
		return w;
	endfunction

	function automatic instr_t enc_jc(cond_t c, int rs);
		instr_t w;
		w.op    = op_jcond;
		w.rdest = c;
		w.imm8  = {4'h0, 4'(rs)};
		return w;
	endfunction

	task automatic write_word(logic [mem_aw-1:0] addr, logic [data_w-1:0] data);
		@(posedge clk);
		host_we    <= 1'b1;
		host_addr  <= addr;
		host_wdata <= data;
		@(posedge clk);
		host_we <= 1'b0;
	endtask

	task automatic read_word(logic [mem_aw-1:0] addr, output logic [data_w-1:0] data);
		@(posedge clk);
		host_addr <= addr;
		@(posedge clk); // port b samples the address
		@(negedge clk);
		data = host_rdata;
	endtask

	// store r3 at the result pointer r7 and step it
	task automatic push_store();
		prog.push_back(enc_rr(op_stor, 3, 7));
		prog.push_back(enc_ri(op_addi, 7, 1));
	endtask

	task automatic load_program();
		logic [mem_aw-1:0] slot;
		slot = slot_base + 8'(runs);
		prog.push_back(enc_ri(op_movi, 14, slot)); // tail goes to this run's halt
		prog.push_back(enc_jc(uc, 14));
		if (runs > 0)
			write_word(slot - 8'd1, enc_jc(uc, 15)); // last halt pc, back to 0 via r15
		write_word(slot, enc_br(nv, 0));
		foreach (prog[i])
			write_word(8'(i), prog[i]);
	endtask

	task automatic run_to_halt();
		int n;
		int limit;
		limit = 200 * prog.size();
		@(posedge clk);
		run <= 1'b1;
		n = 0;
		while (!halted && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!halted)
			abort_run("halted did not rise within the cycle limit");
		repeat (8) begin // held while run stays high
			@(negedge clk);
			if (!halted)
				abort_run("halted fell while run was still high");
		end
		@(posedge clk);
		run <= 1'b0;
		n = 0;
		while (halted && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (halted)
			abort_run("halted stayed high after run fell");
		runs++;
		prog.delete();
	endtask

	task automatic test_alu();
		logic [data_w-1:0] a, b, got;
		logic [data_w-1:0] exp [9];
		logic [7:0]        nimm; // negative addi immediate
		logic [7:0]        mimm;
		op_t               rr_ops [5];
		int                kl, kr, i;
		rr_ops = '{op_add, op_sub, op_and, op_or, op_xor};
		a    = 16'($random(seed));
		b    = 16'($random(seed));
		nimm = 8'h80 | 8'($random(seed));
		mimm = 8'($random(seed));
		kl   = {$random(seed)} % 16;
		kr   = 1 + {$random(seed)} % 15;
		write_word(8'h80, a);
		write_word(8'h81, b);
		prog.push_back(enc_ri(op_movi, 6, 'h80));
		prog.push_back(enc_rr(op_load, 1, 6));
		prog.push_back(enc_ri(op_addi, 6, 1));
		prog.push_back(enc_rr(op_load, 2, 6));
		prog.push_back(enc_ri(op_movi, 7, 'ha0)); // results from a0
		for (i = 0; i < 5; i++) begin
			prog.push_back(enc_rr(op_mov, 3, 1));
			prog.push_back(enc_rr(rr_ops[i], 3, 2));
			push_store();
		end
		prog.push_back(enc_rr(op_mov, 3, 1));
		prog.push_back(enc_ri(op_addi, 3, nimm));
		push_store();
		prog.push_back(enc_ri(op_movi, 3, mimm));
		push_store();
		prog.push_back(enc_rr(op_mov, 3, 1));
		prog.push_back(enc_ri(op_movi, 4, kl));
		prog.push_back(enc_rr(op_lsh, 3, 4));
		push_store();
		prog.push_back(enc_rr(op_mov, 3, 1));
		prog.push_back(enc_ri(op_movi, 4, 32 - kr)); // negative 5-bit count
		prog.push_back(enc_rr(op_lsh, 3, 4));
		push_store();
		load_program();
		run_to_halt();
		exp[0] = a + b;
		exp[1] = a - b;
		exp[2] = a & b;
		exp[3] = a | b;
		exp[4] = a ^ b;
		exp[5] = a + {{8{nimm[7]}}, nimm};
		exp[6] = {8'h00, mimm};
		exp[7] = a << kl;
		exp[8] = a >> kr;
		for (i = 0; i < 9; i++) begin
			read_word(8'(8'ha0 + i), got);
			check_word($sformatf("alu result %0d", i), got, exp[i]);
		end
	endtask

	task automatic test_branch();
		logic [data_w-1:0] va [4];
		logic [data_w-1:0] vb [4];
		logic [data_w-1:0] got;
		cond_t             conds [6];
		int                i, j;
		conds = '{eq, ne, gt, le, hi, ls};
		va[0] = 16'($random(seed));
		vb[0] = 16'($random(seed));
		va[1] = 16'($random(seed));
		vb[1] = va[1];               // equal pair
		va[2] = 16'($random(seed));
		vb[2] = va[2] ^ 16'h8000;    // signed and unsigned order disagree
		va[3] = vb[0];
		vb[3] = va[0];
		for (i = 0; i < 4; i++) begin
			write_word(8'(8'h84 + 2 * i), va[i]);
			write_word(8'(8'h85 + 2 * i), vb[i]);
		end
		prog.push_back(enc_ri(op_movi, 6, 'h84));
		prog.push_back(enc_ri(op_movi, 7, 'ha8));
		for (i = 0; i < 4; i++) begin
			prog.push_back(enc_rr(op_load, 1, 6));
			prog.push_back(enc_ri(op_addi, 6, 1));
			prog.push_back(enc_rr(op_load, 2, 6));
			prog.push_back(enc_ri(op_addi, 6, 1));
			prog.push_back(enc_ri(op_movi, 5, 0));
			prog.push_back(enc_rr(op_cmp, 1, 2));
			for (j = 0; j < 6; j++) begin
				prog.push_back(enc_br(conds[j], 1));        // taken skips the marker
				prog.push_back(enc_ri(op_addi, 5, 1 << j)); // addi leaves z n l alone
			end
			prog.push_back(enc_rr(op_stor, 5, 7));
			prog.push_back(enc_ri(op_addi, 7, 1));
		end
		load_program();
		run_to_halt();
		for (i = 0; i < 4; i++) begin
			read_word(8'(8'ha8 + i), got);
			check_flags_word($sformatf("branch pair %0d", i), cmp_flags(va[i], vb[i]), got);
		end
	endtask

	task automatic test_load_store();
		logic [data_w-1:0] tab [8];
		logic [data_w-1:0] got;
		int                i;
		for (i = 0; i < 8; i++) begin
			tab[i] = 16'($random(seed));
			write_word(8'(8'h90 + i), tab[i]);
		end
		prog.push_back(enc_ri(op_movi, 6, 'h90)); // table pointer
		prog.push_back(enc_ri(op_movi, 8, 'hb0)); // sum pointer
		for (i = 0; i < 4; i++) begin
			prog.push_back(enc_rr(op_load, 1, 6));
			prog.push_back(enc_ri(op_addi, 6, 1));
			prog.push_back(enc_rr(op_load, 2, 6));
			prog.push_back(enc_ri(op_addi, 6, 1));
			prog.push_back(enc_rr(op_add, 1, 2));
			prog.push_back(enc_rr(op_stor, 1, 8));
			prog.push_back(enc_ri(op_addi, 8, 1));
		end
		load_program();
		run_to_halt();
		for (i = 0; i < 4; i++) begin
			read_word(8'(8'hb0 + i), got);
			check_word($sformatf("pair sum %0d", i), got, tab[2 * i] + tab[2 * i + 1]);
		end
		for (i = 0; i < 8; i++) begin // source table untouched
			read_word(8'(8'h90 + i), got);
			check_word($sformatf("table word %0d", i), got, tab[i]);
		end
	endtask

	task automatic test_loop();
		logic [data_w-1:0] got;
		int                n;
		n = 3 + {$random(seed)} % 8;
		prog.push_back(enc_ri(op_movi, 1, n));
		prog.push_back(enc_ri(op_movi, 2, 0));
		prog.push_back(enc_ri(op_movi, 4, 0));
		prog.push_back(enc_ri(op_movi, 5, n));
		prog.push_back(enc_ri(op_movi, 9, prog.size() + 1)); // loop head
		prog.push_back(enc_rr(op_add, 2, 1));  // sum n down to 1
		prog.push_back(enc_ri(op_subi, 1, 1));
		prog.push_back(enc_ri(op_cmpi, 1, 0));
		prog.push_back(enc_br(eq, 1));         // done, skip the jump back
		prog.push_back(enc_jc(uc, 9));
		prog.push_back(enc_ri(op_addi, 4, 1)); // count with a backward branch
		prog.push_back(enc_ri(op_subi, 5, 1));
		prog.push_back(enc_ri(op_cmpi, 5, 0));
		prog.push_back(enc_br(ne, -4));
		prog.push_back(enc_ri(op_movi, 7, 'hb8));
		prog.push_back(enc_rr(op_stor, 2, 7));
		prog.push_back(enc_ri(op_addi, 7, 1));
		prog.push_back(enc_rr(op_stor, 4, 7));
		load_program();
		run_to_halt();
		read_word(8'hb8, got);
		check_word("loop sum", got, 16'(n * (n + 1) / 2));
		read_word(8'hb9, got);
		check_word("loop count", got, 16'(n));
	endtask

	task automatic test_halt_run();
		logic [data_w-1:0] got;
		logic [7:0]        mark [2];
		int                k;
		mark[0] = 8'($random(seed));
		mark[1] = mark[0] ^ 8'h5a; // second program leaves a different mark
		for (k = 0; k < 2; k++) begin
			prog.push_back(enc_ri(op_movi, 7, 'hc0));
			prog.push_back(enc_ri(op_movi, 1, mark[k]));
			prog.push_back(enc_rr(op_stor, 1, 7));
			load_program();
			if (k > 0) begin
				repeat (20) @(posedge clk); // new program sits loaded, run still low
				read_word(8'hc0, got);
				check_word("mark while run low", got, {8'h00, mark[0]});
			end
			run_to_halt();
			read_word(8'hc0, got);
			check_word($sformatf("restart mark %0d", k), got, {8'h00, mark[k]});
		end
	endtask

	initial begin
		reset      = 1'b0;
		run        = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		runs       = 0;
		repeat (4) @(posedge clk);
		reset <= 1'b1;
		repeat (20) begin // idle with run low
			@(negedge clk);
			if (halted)
				abort_run("halted rose while run was low after reset");
		end
		test_alu();
		test_branch();
		test_load_store();
		test_loop();
		test_halt_run();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/cpu_top.sv
`default_nettype none

module cpu_top import cpu_pkg::*; (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              run,
	output logic                   halted,
	input  wire logic              host_we,
	input  wire logic [mem_aw-1:0] host_addr,
	input  wire logic [data_w-1:0] host_wdata,
	output logic [data_w-1:0]      host_rdata
);

	ctrl_t             ctrl;
	op_t               op;
	flags_t            flags;
	logic [reg_aw-1:0] rdest;
	logic [reg_aw-1:0] rsrc;
	logic [data_w-1:0] imm;
	logic [data_w-1:0] disp;
	logic [data_w-1:0] pc;
	logic [data_w-1:0] mem_q;      // port a read word
	logic [data_w-1:0] rdata_a;    // rdest value, store data
	logic [data_w-1:0] rdata_b;    // rsrc value, address and jump target
	logic [data_w-1:0] alu_result;

	control_decoder u_ctrl (
		.clk    (clk),
		.reset  (reset),
		.run    (run),
		.mem_q  (mem_q),
		.flags  (flags),
		.ctrl   (ctrl),
		.op     (op),
		.rdest  (rdest),
		.rsrc   (rsrc),
		.imm    (imm),
		.disp   (disp),
		.halted (halted)
	);

	program_counter u_pc (
		.clk      (clk),
		.reset    (reset),
		.ctrl     (ctrl),
		.disp     (disp),
		.tgt_addr (rdata_b),
		.pc       (pc)
	);

	regfile u_regs (
		.clk        (clk),
		.reset      (reset),
		.ctrl       (ctrl),
		.raddr_a    (rdest),
		.raddr_b    (rsrc),
		.alu_result (alu_result),
		.mem_q      (mem_q),
		.rdata_a    (rdata_a),
		.rdata_b    (rdata_b)
	);

	alu u_alu (
		.clk    (clk),
		.reset  (reset),
		.ctrl   (ctrl),
		.op     (op),
		.a      (rdata_a),
		.b_reg  (rdata_b),
		.imm    (imm),
		.result (alu_result),
		.flags  (flags)
	);

	// port a for the cpu, port b for the host
	word_ram u_ram (
		.clk        (clk),
		.ctrl       (ctrl),
		.pc         (pc),
		.data_addr  (rdata_b),
		.wdata      (rdata_a),
		.q          (mem_q),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata)
	);

endmodule

`default_nettype wire

//--- source/control_decoder.sv
`default_nettype none

module control_decoder import cpu_pkg::*; (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              run,
	input  wire logic [data_w-1:0] mem_q,
	input  wire flags_t            flags,
	output ctrl_t                  ctrl,
	output op_t                    op,
	output logic [reg_aw-1:0]      rdest,
	output logic [reg_aw-1:0]      rsrc,
	output logic [data_w-1:0]      imm,
	output logic [data_w-1:0]      disp,
	output logic                   halted
);

	state_t state, state_nxt;
	instr_t ir;
	cond_t  cond;
	logic   taken;   // condition holds
	logic   is_halt; // bcond nv

	// instruction register, word arrives in decode
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			ir <= '0;
		end else if (state == s_decode) begin
			ir <= instr_t'(mem_q);
		end
	end

	// field decode
	assign op    = ir.op;
	assign rdest = ir.rdest;
	assign rsrc  = ir.imm8[reg_aw-1:0];
	assign cond  = cond_t'(ir.rdest);
	assign disp  = {{(data_w-8){ir.imm8[7]}}, ir.imm8};

	always_comb begin
		case (ir.op)
			op_and, op_or, op_xor, op_movi: imm = {{(data_w-8){1'b0}}, ir.imm8}; // logic ops
			default:                         imm = {{(data_w-8){ir.imm8[7]}}, ir.imm8};
		endcase
	end

	// condition against the flag register, a is rdest and b is rsrc
	always_comb begin
		case (cond)
			eq:      taken = flags.z;
			ne:      taken = !flags.z;
			cs:      taken = flags.c;
			cc:      taken = !flags.c;
			hi:      taken = !flags.l && !flags.z; // unsigned greater
			ls:      taken = flags.l || flags.z;
			gt:      taken = !flags.n && !flags.z; // signed greater
			le:      taken = flags.n || flags.z;
			uc:      taken = 1'b1;
			default: taken = 1'b0; // nv and unused codes
		endcase
	end

	assign is_halt = (ir.op == op_bcond) && (cond == nv);

	// next state
	always_comb begin
		state_nxt = state;
		case (state)
			s_fetch:   if (run) state_nxt = s_decode; // hold until the host lets go
			s_decode:  state_nxt = s_exec;
			s_exec: begin
				if (ir.op == op_load || ir.op == op_stor)
					state_nxt = s_mem;
				else if (is_halt)
					state_nxt = s_halt;
				else
					state_nxt = s_fetch;
			end
			s_mem:     state_nxt = (ir.op == op_load) ? s_load_wb : s_fetch;
			s_load_wb: state_nxt = s_fetch;
			s_halt:    if (run && !halted) state_nxt = s_fetch; // run dropped and came back
			default:   state_nxt = s_fetch;
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state  <= s_fetch;
			halted <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == s_exec && is_halt)
				halted <= 1'b1;
			else if (state == s_halt && !run)
				halted <= 1'b0;
		end
	end

	// per-state control, all zero in fetch and halt
	always_comb begin
		ctrl         = '0;
		ctrl.pc_mode = pc_inc;
		ctrl.mem_sel = sel_instr;
		case (state)
			s_exec: begin
				case (ir.op)
					op_add, op_sub, op_and, op_or, op_xor, op_mov, op_lsh: begin
						ctrl.reg_we = 1'b1;
						ctrl.pc_en  = 1'b1;
					end
					op_addi, op_subi, op_movi: begin
						ctrl.reg_we  = 1'b1;
						ctrl.use_imm = 1'b1;
						ctrl.pc_en   = 1'b1;
					end
					op_cmp: ctrl.pc_en = 1'b1;
					op_cmpi: begin
						ctrl.use_imm = 1'b1;
						ctrl.pc_en   = 1'b1;
					end
					op_load, op_stor: begin
						ctrl.mem_sel = sel_data; // address out now, access next cycle
						ctrl.pc_en   = 1'b1;
					end
					op_bcond: begin
						ctrl.pc_en   = !is_halt; // halt leaves pc on itself
						ctrl.pc_mode = taken ? pc_disp : pc_inc;
					end
					default: begin // op_jcond
						ctrl.pc_en   = 1'b1;
						ctrl.pc_mode = taken ? pc_jump : pc_inc;
					end
				endcase
				// arithmetic and compares touch flags
				case (ir.op)
					op_add, op_addi, op_sub, op_subi, op_cmp, op_cmpi: ctrl.flags_we = 1'b1;
					default:                                           ctrl.flags_we = 1'b0;
				endcase
			end
			s_mem: begin
				ctrl.mem_sel = sel_data;
				ctrl.mem_we  = (ir.op == op_stor);
			end
			s_load_wb: begin
				ctrl.mem_sel     = sel_data; // keep q on the data word
				ctrl.reg_we      = 1'b1;
				ctrl.wb_from_mem = 1'b1;
			end
			default: ;
		endcase
	end

	// stores only ever follow the exec cycle of a store
	a_store_after_exec: assert property (@(posedge clk) disable iff (!reset)
		ctrl.mem_we |-> state == s_mem && $past(state) == s_exec && op == op_stor);

	a_no_we_overlap: assert property (@(posedge clk) disable iff (!reset)
		!(ctrl.reg_we && ctrl.mem_we));

endmodule

`default_nettype wire

//--- source/word_ram.sv
`default_nettype none

module word_ram import cpu_pkg::*; (
	input  wire logic              clk,
	input  wire ctrl_t             ctrl,
	input  wire logic [data_w-1:0] pc,
	input  wire logic [data_w-1:0] data_addr,
	input  wire logic [data_w-1:0] wdata,
	output logic [data_w-1:0]      q,
	input  wire logic              host_we,
	input  wire logic [mem_aw-1:0] host_addr,
	input  wire logic [data_w-1:0] host_wdata,
	output logic [data_w-1:0]      host_rdata
);

	logic [data_w-1:0] mem [mem_depth];
	logic [mem_aw-1:0] addr_a;

	// fetch or data, upper bits dropped
	assign addr_a = (ctrl.mem_sel == sel_data) ? data_addr[mem_aw-1:0] : pc[mem_aw-1:0];

	// both ports in one process, reads return the old word
	always_ff @(posedge clk) begin
		if (ctrl.mem_we)
			mem[addr_a] <= wdata;    // cpu store
		if (host_we)
			mem[host_addr] <= host_wdata;
		q          <= mem[addr_a];
		host_rdata <= mem[host_addr];
	end

endmodule

`default_nettype wire

//--- source/program_counter.sv
`default_nettype none

module program_counter import cpu_pkg::*; (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire ctrl_t             ctrl,
	input  wire logic [data_w-1:0] disp,     // already sign extended
	input  wire logic [data_w-1:0] tgt_addr, // jump register
	output logic [data_w-1:0]      pc
);

	logic [data_w-1:0] pc_nxt;

	always_comb begin
		case (ctrl.pc_mode)
			pc_disp: pc_nxt = pc + disp + data_w'(1); // relative to the next word
			pc_jump: pc_nxt = tgt_addr;
			default: pc_nxt = pc + data_w'(1);
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			pc <= '0;
		else if (ctrl.pc_en)
			pc <= pc_nxt;
	end

endmodule

`default_nettype wire

//--- source/regfile.sv
`default_nettype none

module regfile import cpu_pkg::*; (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire ctrl_t             ctrl,
	input  wire logic [reg_aw-1:0] raddr_a,    // rdest, also the write index
	input  wire logic [reg_aw-1:0] raddr_b,    // rsrc
	input  wire logic [data_w-1:0] alu_result,
	input  wire logic [data_w-1:0] mem_q,
	output logic [data_w-1:0]      rdata_a,
	output logic [data_w-1:0]      rdata_b
);

	logic [data_w-1:0] regs [reg_count];
	logic [data_w-1:0] wdata;

	assign wdata = ctrl.wb_from_mem ? mem_q : alu_result; // load or alu

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (ctrl.reg_we) begin
			regs[raddr_a] <= wdata;
		end
	end

	// async reads
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

	// load writeback must see a defined word from the ram
	a_load_data_known: assert property (@(posedge clk) disable iff (!reset)
		ctrl.reg_we && ctrl.wb_from_mem |-> !$isunknown(mem_q));

endmodule

`default_nettype wire

//--- source/alu.sv
`default_nettype none

module alu import cpu_pkg::*; (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire ctrl_t             ctrl,
	input  wire op_t               op,
	input  wire logic [data_w-1:0] a,
	input  wire logic [data_w-1:0] b_reg,
	input  wire logic [data_w-1:0] imm,
	output logic [data_w-1:0]      result,
	output flags_t                 flags
);

	logic [data_w-1:0] b;
	logic [data_w:0]   sum_ext;  // carry in msb
	logic [data_w:0]   diff_ext; // no-borrow in msb
	logic              add_ovf;
	logic              sub_ovf;
	logic signed [4:0] sh;       // signed shift count
	logic [4:0]        sh_mag;
	flags_t            flags_nxt;

	assign b = ctrl.use_imm ? imm : b_reg;

	assign sum_ext  = {1'b0, a} + {1'b0, b};
	assign diff_ext = {1'b0, a} + {1'b0, ~b} + (data_w + 1)'(1); // a + ~b + 1
	assign add_ovf  = (a[data_w-1] == b[data_w-1]) && (sum_ext[data_w-1] != a[data_w-1]);
	assign sub_ovf  = (a[data_w-1] != b[data_w-1]) && (diff_ext[data_w-1] != a[data_w-1]);

	assign sh     = b[4:0];
	assign sh_mag = -sh; // 16 shifts everything out

	always_comb begin
		case (op)
			op_add, op_addi: result = sum_ext[data_w-1:0];
			op_sub, op_subi: result = diff_ext[data_w-1:0];
			op_and:          result = a & b;
			op_or:           result = a | b;
			op_xor:          result = a ^ b;
			op_mov, op_movi: result = b;
			op_lsh: begin
				if (sh[4])
					result = a >> sh_mag;  // negative count, go right
				else
					result = a << sh[3:0];
			end
			op_cmp, op_cmpi: result = diff_ext[data_w-1:0]; // not written back
			default:         result = a;
		endcase
	end

	// only the flags an op owns change, rest carry over
	always_comb begin
		flags_nxt = flags;
		case (op)
			op_add, op_addi: begin
				flags_nxt.c = sum_ext[data_w];
				flags_nxt.f = add_ovf;
			end
			op_sub, op_subi: begin
				flags_nxt.c = diff_ext[data_w];
				flags_nxt.f = sub_ovf;
			end
			op_cmp, op_cmpi: begin
				flags_nxt.z = (diff_ext[data_w-1:0] == '0);
				flags_nxt.n = $signed(a) < $signed(b);
				flags_nxt.l = a < b;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			flags <= '0;
		else if (ctrl.flags_we)
			flags <= flags_nxt;
	end

endmodule

`default_nettype wire

//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// word and memory sizes
	localparam int data_w    = 16;
	localparam int mem_aw    = 8;    // cpu addresses above this are dropped
	localparam int mem_depth = 256;
	localparam int reg_count = 16;
	localparam int reg_aw    = 4;    // register index width

	// port a address select
	localparam logic sel_instr = 1'b0; // pc drives the address
	localparam logic sel_data  = 1'b1; // rsrc register drives the address

	// opcodes, op_jcond must stay at 15
	typedef enum logic [3:0] {
		op_add,
		op_addi,
		op_sub,
		op_subi,
		op_and,
		op_or,
		op_xor,
		op_mov,
		op_movi,
		op_lsh,
		op_cmp,
		op_cmpi,
		op_load,
		op_stor,
		op_bcond,
		op_jcond
	} op_t;

	// branch conditions, carried in the rdest field
	typedef enum logic [3:0] {
		eq, ne, cs, cc, hi, ls, gt, le, uc, nv
	} cond_t;

	// instruction word
	typedef struct packed {
		op_t              op;
		logic [reg_aw-1:0] rdest; // condition for bcond and jcond
		logic [7:0]       imm8;  // low nibble is rsrc in register forms
	} instr_t;

	typedef struct packed {
		logic c; // carry, or no borrow
		logic l; // unsigned less
		logic f; // signed overflow
		logic z; // zero
		logic n; // signed less
	} flags_t;

	typedef enum logic [2:0] {
		s_fetch,
		s_decode,
		s_exec,
		s_mem,
		s_load_wb,
		s_halt
	} state_t;

	typedef enum logic [1:0] {
		pc_inc,  // pc + 1
		pc_disp, // pc + disp + 1
		pc_jump  // register target
	} pc_mode_t;

	// one-cycle control levels from the FSM
	typedef struct packed {
		logic     pc_en;
		pc_mode_t pc_mode;
		logic     reg_we;
		logic     wb_from_mem; // regfile writes mem_q instead of alu result
		logic     use_imm;     // alu b operand from imm
		logic     flags_we;
		logic     mem_sel;     // sel_instr or sel_data
		logic     mem_we;
	} ctrl_t;

endpackage

`default_nettype wire
